/* dv/spart_mem_checker.sv */
`timescale 1ns/100ps

`include "spart_mem_params.svh"

module spart_mem_checker (
	input  logic        clk,
	input  logic        rst,
	input  logic        txd,
	input  logic        expect_valid,
	input  logic [31:0] expect_word,
	output logic        done,
	output int          err_cnt
);

	logic [31:0] exp_word;
	int          exp_cnt;
	int          done_cnt;
	int          nbytes;
	logic [31:0] got_word;
	logic [7:0]  frame_bits;

	// Expected word per read, count of reads handed over
	always @(posedge clk)
	begin
		if (rst)
			exp_cnt <= 0;
		else if (expect_valid)
		begin
			exp_word <= expect_word;
			exp_cnt  <= exp_cnt + 1;
		end
	end

	////////////////////////////////////////
	// Frame decode on txd
	////////////////////////////////////////

	initial
	begin
		done <= 1'b0;
		err_cnt = 0;
		done_cnt = 0;
		nbytes = 0;
		got_word = '0;
		forever
		begin
			@(posedge clk);
			if (!rst && !txd)
			begin
				// Middle of start bit
				repeat (`CLKS_PER_BIT / 2 - 1) @(posedge clk);
				if (txd)
				begin
					$display("ERROR at %0t: txd start bit too short", $time);
					err_cnt++;
					continue;
				end
				for (int i = 0; i < 8; i++)
				begin
					repeat (`CLKS_PER_BIT) @(posedge clk);
					frame_bits[i] = txd;
				end
				repeat (`CLKS_PER_BIT) @(posedge clk);
				if (!txd)
				begin
					$display("ERROR at %0t: txd stop bit low", $time);
					err_cnt++;
				end
				if (nbytes == 0 && exp_cnt == done_cnt)
				begin
					$display("ERROR at %0t: byte %02h on txd with no read pending",
						$time, frame_bits);
					err_cnt++;
					continue;
				end
				// Bytes come back LSB first
				got_word = {frame_bits, got_word[31:8]};
				nbytes++;
				if (nbytes == 4)
				begin
					if (got_word !== exp_word)
					begin
						$display("CHECK FAILED at %0t: read returned %08h, expected %08h",
							$time, got_word, exp_word);
						err_cnt++;
					end
					nbytes = 0;
					done_cnt++;
					done <= 1'b1;
					@(posedge clk);
					done <= 1'b0;
				end
			end
		end
	end

endmodule

/* dv/spart_mem_properties.sv */
`timescale 1ns/100ps

module spart_mem_properties (
	input logic clk,
	input logic rst,
	input logic rx_valid,
	input logic tx_start,
	input logic tx_busy,
	input logic txd
);

	// Failed assertions so far
	int assert_errs = 0;

	////////////////////////////////////////
	// Strobes
	////////////////////////////////////////

	// Received byte strobe lasts one cycle
	rx_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		rx_valid |=> !rx_valid)
		else
		begin
			$error("rx_valid held longer than one cycle");
			assert_errs++;
		end

	// Send strobe lasts one cycle
	tx_start_pulse: assert property (@(posedge clk) disable iff (rst)
		tx_start |=> !tx_start)
		else
		begin
			$error("tx_start held longer than one cycle");
			assert_errs++;
		end

	// Engine only starts an idle transmitter
	tx_start_idle: assert property (@(posedge clk) disable iff (rst)
		tx_start |-> !tx_busy)
		else
		begin
			$error("tx_start while tx_busy high");
			assert_errs++;
		end

	////////////////////////////////////////
	// Line level
	////////////////////////////////////////

	// Idle transmitter keeps the line high
	txd_idle_high: assert property (@(posedge clk) disable iff (rst)
		!tx_busy |-> txd)
		else
		begin
			$error("txd low while tx_busy low");
			assert_errs++;
		end

endmodule

/* dv/spart_mem_tests.txt */
# kind opcode data expected; W write, R read, B frame with low stop bit (hex fields)
# data ffffffff is a random word; W op ff random address; R op 7f oldest random; exp ffffffff last written
R 03 00000000 00000000
R 0f 00000000 00000000
W 85 a1b2c3d4 00000000
R 05 00000000 a1b2c3d4
W 8a 11223344 00000000
W f2 55667788 00000000
R 0a 00000000 11223344
R 72 00000000 55667788
W 8a cafef00d 00000000
R 0a 00000000 cafef00d
B 05 00000000 00000000
R 05 00000000 a1b2c3d4
W ff ffffffff 00000000
W ff ffffffff 00000000
W ff ffffffff 00000000
W ff ffffffff 00000000
R 7f 00000000 ffffffff
R 7f 00000000 ffffffff
R 7f 00000000 ffffffff
R 7f 00000000 ffffffff

/* dv/tb_spart_mem.sv */
`timescale 1ns/100ps

`include "spart_mem_params.svh"

module tb_spart_mem;

	logic        clk;
	logic        rst;
	logic        rxd;
	logic        txd;
	logic        expect_valid;
	logic [31:0] expect_word;
	logic        done;
	int          chk_errs;
	logic [31:0] shadow [16];
	logic [3:0]  rand_addrs [$];
	int          test_cnt;
	int          fail_cnt;

	spart_mem_top u_spart_mem_top (
		.clk (clk),
		.rst (rst),
		.rxd (rxd),
		.txd (txd)
	);

	spart_mem_checker u_checker (
		.clk          (clk),
		.rst          (rst),
		.txd          (txd),
		.expect_valid (expect_valid),
		.expect_word  (expect_word),
		.done         (done),
		.err_cnt      (chk_errs)
	);

	bind spart_mem_top spart_mem_properties u_properties (
		.clk      (clk),
		.rst      (rst),
		.rx_valid (rx_valid),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.txd      (txd)
	);

	// 40 ns clock
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// Serial stimulus
	////////////////////////////////////////

	task automatic send_bit(input logic b);
		@(posedge clk);
		rxd <= b;
		repeat (`CLKS_PER_BIT - 1) @(posedge clk);
	endtask

	// 8N1 frame with caller-chosen stop level
	task automatic send_frame(input logic [7:0] data, input logic stop);
		send_bit(1'b0);
		for (int i = 0; i < 8; i++)
			send_bit(data[i]);
		send_bit(stop);
		if (!stop)
			send_bit(1'b1);
	endtask

	task automatic send_word(input logic [31:0] w);
		for (int i = 0; i < 4; i++)
			send_frame(w[8*i +: 8], 1'b1);
	endtask

	task automatic post_expect(input logic [31:0] w);
		@(posedge clk);
		expect_valid <= 1'b1;
		expect_word  <= w;
		@(posedge clk);
		expect_valid <= 1'b0;
	endtask

	// Bounded by 100 bit times
	task automatic wait_done(output bit got);
		int cycles;
		got = 1'b0;
		for (cycles = 0; cycles < 100 * `CLKS_PER_BIT; cycles++)
		begin
			@(posedge clk);
			if (done)
			begin
				got = 1'b1;
				break;
			end
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		int          fd;
		string       line;
		byte         kind;
		logic [7:0]  op;
		logic [31:0] data;
		logic [31:0] exp_w;
		logic [3:0]  addr;
		int          errs_before;
		int          asrt_before;
		bit          ok;
		bit          got;
		rst = 1'b1;
		rxd = 1'b1;
		expect_valid = 1'b0;
		expect_word = '0;
		test_cnt = 0;
		fail_cnt = 0;
		void'($urandom(32'he0fce280));
		// Store is all zero after reset
		for (int i = 0; i < 16; i++)
			shadow[i] = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (4 * `CLKS_PER_BIT) @(posedge clk);
		fd = $fopen("dv/spart_mem_tests.txt", "r");
		if (fd == 0)
		begin
			$display("ERROR: cannot open dv/spart_mem_tests.txt");
			fail_cnt++;
		end
		while (fd != 0 && !$feof(fd))
		begin
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() < 2 || line[0] == "#")
				continue;
			if ($sscanf(line, "%c %h %h %h", kind, op, data, exp_w) != 4)
			begin
				$display("ERROR: malformed line in tests file: %s", line);
				fail_cnt++;
				continue;
			end
			test_cnt++;
			errs_before = chk_errs;
			asrt_before = u_spart_mem_top.u_properties.assert_errs;
			ok = 1'b1;
			case (kind)
				"W":
				begin
					// ff picks a random address
					if (op == 8'hff)
					begin
						addr = 4'($urandom);
						rand_addrs.push_back(addr);
						op = {4'h8, addr};
					end
					else
						addr = op[3:0];
					if (data == 32'hffffffff)
						data = $urandom;
					shadow[addr] = data;
					send_frame(op, 1'b1);
					send_word(data);
				end
				"R":
				begin
					// 7f reads back the oldest random write
					if (op == 8'h7f)
					begin
						if (rand_addrs.size() == 0)
						begin
							$display("ERROR: random read with no random write before it");
							addr = '0;
							ok = 1'b0;
						end
						else
							addr = rand_addrs.pop_front();
						op = {4'h0, addr};
					end
					else
						addr = op[3:0];
					if (exp_w == 32'hffffffff)
						exp_w = shadow[addr];
					post_expect(exp_w);
					send_frame(op, 1'b1);
					wait_done(got);
					if (!got)
					begin
						$display("ERROR at %0t: no response to read of address %0d",
							$time, addr);
						ok = 1'b0;
					end
				end
				"B":
				begin
					send_frame(op, 1'b0);
					// Window for any stray response
					repeat (12 * `CLKS_PER_BIT) @(posedge clk);
				end
				default:
				begin
					$display("ERROR: unknown test kind %c", kind);
					ok = 1'b0;
				end
			endcase
			repeat (2 * `CLKS_PER_BIT) @(posedge clk);
			if (chk_errs != errs_before)
				ok = 1'b0;
			if (u_spart_mem_top.u_properties.assert_errs != asrt_before)
				ok = 1'b0;
			if (!ok)
				fail_cnt++;
			$display("test %0d %c op %02h: %s", test_cnt, kind, op, ok ? "ok" : "error");
		end
		if (fd != 0)
			$fclose(fd);
		$display("tests %0d, failed %0d, checker errors %0d, assertion errors %0d",
			test_cnt, fail_cnt, chk_errs, u_spart_mem_top.u_properties.assert_errs);
		if (fail_cnt == 0 && chk_errs == 0 && test_cnt > 0
			&& u_spart_mem_top.u_properties.assert_errs == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* rtl/cmd_engine.sv */
`timescale 1ns/100ps

`include "spart_mem_params.svh"

module cmd_engine (
	input  logic             clk,
	input  logic             rst,
	input  spart_pkg::byte_t rx_byte,
	input  logic             rx_valid,
	input  logic             tx_busy,
	output spart_pkg::byte_t tx_byte,
	output logic             tx_start
);

	// Bytes per word
	localparam logic [2:0] WORD_BYTES = 3'd4;

	mem_pkg::cmd_state_e state;
	mem_pkg::word_t      mem [`MEM_DEPTH];
	mem_pkg::addr_t      addr;
	mem_pkg::addr_t      op_addr;
	mem_pkg::word_t      data_word;
	logic [2:0]          byte_cnt;
	logic                wr_en;
	logic                send_slot;

	// Opcode low bits select the word, bits 6..4 ignored
	assign op_addr = rx_byte[`MEM_ADDR_BITS-1:0];

	// Transmitter free and bytes still to go
	assign send_slot = (state == mem_pkg::SEND) && !tx_busy && !tx_start
		&& (byte_cnt != WORD_BYTES);

	////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= mem_pkg::OPCODE;
			addr     <= '0;
			byte_cnt <= '0;
			wr_en    <= 1'b0;
			tx_start <= 1'b0;
		end
		else
		begin
			wr_en    <= 1'b0;
			tx_start <= 1'b0;
			case (state)
				mem_pkg::OPCODE:
				begin
					byte_cnt <= '0;
					if (rx_valid)
					begin
						addr <= op_addr;
						// Bit 7 set is a write
						if (rx_byte[7])
							state <= mem_pkg::COLLECT;
						else
							state <= mem_pkg::SEND;
					end
				end
				mem_pkg::COLLECT:
				begin
					if (rx_valid)
					begin
						byte_cnt <= byte_cnt + 1'b1;
						// Fourth byte, commit next cycle
						if (byte_cnt == WORD_BYTES - 1'b1)
						begin
							wr_en <= 1'b1;
							state <= mem_pkg::OPCODE;
						end
					end
				end
				mem_pkg::SEND:
				begin
					// Serial input ignored here
					if (send_slot)
					begin
						tx_start <= 1'b1;
						byte_cnt <= byte_cnt + 1'b1;
					end
					else if (byte_cnt == WORD_BYTES && !tx_busy && !tx_start)
						state <= mem_pkg::OPCODE;
				end
				default:
					state <= mem_pkg::OPCODE;
			endcase
		end
	end

	////////////////////////////////////////
	// Word datapath
	////////////////////////////////////////

	// Assemble LSB first on writes, fetch and drain LSB first on reads
	always_ff @(posedge clk)
	begin
		if (state == mem_pkg::OPCODE && rx_valid && !rx_byte[7])
			data_word <= mem[op_addr];
		else if (state == mem_pkg::COLLECT && rx_valid)
			data_word <= {rx_byte, data_word[31:8]};
		else if (send_slot)
		begin
			tx_byte   <= data_word[7:0];
			data_word <= data_word >> 8;
		end
	end

	// Store starts all zero
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `MEM_DEPTH; i++)
				mem[i] <= '0;
		end
		else if (wr_en)
			mem[addr] <= data_word;
	end

endmodule

/* rtl/mem_pkg.sv */
`include "spart_mem_params.svh"

package mem_pkg;

	// Stored word
	typedef logic [31:0] word_t;

	// Word address, low opcode bits
	typedef logic [`MEM_ADDR_BITS-1:0] addr_t;

	// Command engine FSM
	// OPCODE waits for a command byte
	// COLLECT gathers four write bytes
	// SEND streams a word back on txd
	typedef enum logic [1:0]
	{
		OPCODE,
		COLLECT,
		SEND
	} cmd_state_e;

endpackage

/* rtl/spart_mem_params.svh */
`ifndef SPART_MEM_PARAMS_SVH
`define SPART_MEM_PARAMS_SVH

////////////////////////////////////////
// Serial link timing
////////////////////////////////////////

// Clock cycles per serial bit
`define CLKS_PER_BIT 16

// Bit-time counter width, must hold CLKS_PER_BIT - 1
`define BIT_CNT_BITS 8

////////////////////////////////////////
// Word store geometry
////////////////////////////////////////

// Address bits of the word memory
`define MEM_ADDR_BITS 4

// Number of stored words
`define MEM_DEPTH (1 << `MEM_ADDR_BITS)

`endif

/* rtl/spart_mem_top.sv */
`timescale 1ns/100ps

module spart_mem_top (
	input  logic clk,
	input  logic rst,
	input  logic rxd,
	output logic txd
);

	spart_pkg::byte_t rx_byte;
	logic             rx_valid;
	spart_pkg::byte_t tx_byte;
	logic             tx_start;
	logic             tx_busy;

	// Serial in
	spart_rx u_spart_rx (
		.clk      (clk),
		.rst      (rst),
		.rxd      (rxd),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	// Opcode decode and word store
	cmd_engine u_cmd_engine (
		.clk      (clk),
		.rst      (rst),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.tx_busy  (tx_busy),
		.tx_byte  (tx_byte),
		.tx_start (tx_start)
	);

	// Serial out
	spart_tx u_spart_tx (
		.clk      (clk),
		.rst      (rst),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.txd      (txd),
		.tx_busy  (tx_busy)
	);

endmodule

/* rtl/spart_pkg.sv */
`include "spart_mem_params.svh"

package spart_pkg;

	// One serial payload
	typedef logic [7:0] byte_t;

	// Counts clocks inside one bit time
	typedef logic [`BIT_CNT_BITS-1:0] baud_cnt_t;

	// Receiver FSM
	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// Transmitter FSM
	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

endpackage

/* rtl/spart_rx.sv */
`timescale 1ns/100ps

`include "spart_mem_params.svh"

module spart_rx (
	input  logic             clk,
	input  logic             rst,
	input  logic             rxd,
	output spart_pkg::byte_t rx_byte,
	output logic             rx_valid
);

	// Last count of a half and a full bit time
	localparam spart_pkg::baud_cnt_t HALF_LAST = spart_pkg::baud_cnt_t'(`CLKS_PER_BIT / 2 - 1);
	localparam spart_pkg::baud_cnt_t BIT_LAST  = spart_pkg::baud_cnt_t'(`CLKS_PER_BIT - 1);

	logic                 rxd_meta;
	logic                 rxd_sync;
	spart_pkg::rx_state_e state;
	spart_pkg::baud_cnt_t baud_cnt;
	logic [2:0]           bit_idx;
	spart_pkg::byte_t     shreg;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= spart_pkg::RX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			case (state)
				spart_pkg::RX_IDLE:
				begin
					baud_cnt <= '0;
					bit_idx  <= '0;
					// Falling edge may be a start bit
					if (!rxd_sync)
						state <= spart_pkg::RX_START;
				end
				spart_pkg::RX_START:
				begin
					if (baud_cnt == HALF_LAST)
					begin
						baud_cnt <= '0;
						// Glitch check at mid start bit
						if (!rxd_sync)
							state <= spart_pkg::RX_DATA;
						else
							state <= spart_pkg::RX_IDLE;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				spart_pkg::RX_DATA:
				begin
					if (baud_cnt == BIT_LAST)
					begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= spart_pkg::RX_STOP;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				spart_pkg::RX_STOP:
				begin
					if (baud_cnt == BIT_LAST)
					begin
						state    <= spart_pkg::RX_IDLE;
						// Low stop bit means framing error, drop byte
						rx_valid <= rxd_sync;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				default:
					state <= spart_pkg::RX_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first, sampled mid bit
	always_ff @(posedge clk)
	begin
		if (state == spart_pkg::RX_DATA && baud_cnt == BIT_LAST)
			shreg <= {rxd_sync, shreg[7:1]};
	end

	assign rx_byte = shreg;

endmodule

/* rtl/spart_tx.sv */
`timescale 1ns/100ps

`include "spart_mem_params.svh"

module spart_tx (
	input  logic             clk,
	input  logic             rst,
	input  spart_pkg::byte_t tx_byte,
	input  logic             tx_start,
	output logic             txd,
	output logic             tx_busy
);

	localparam spart_pkg::baud_cnt_t BIT_LAST = spart_pkg::baud_cnt_t'(`CLKS_PER_BIT - 1);

	spart_pkg::tx_state_e state;
	spart_pkg::baud_cnt_t baud_cnt;
	logic [2:0]           bit_idx;
	spart_pkg::byte_t     shreg;

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= spart_pkg::TX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			tx_busy  <= 1'b0;
		end
		else
		begin
			// Busy from the cycle after start until one cycle past the stop bit
			tx_busy <= tx_start || (state != spart_pkg::TX_IDLE);
			case (state)
				spart_pkg::TX_IDLE:
				begin
					baud_cnt <= '0;
					bit_idx  <= '0;
					if (tx_start)
						state <= spart_pkg::TX_START;
				end
				spart_pkg::TX_START:
				begin
					if (baud_cnt == BIT_LAST)
					begin
						baud_cnt <= '0;
						state    <= spart_pkg::TX_DATA;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				spart_pkg::TX_DATA:
				begin
					if (baud_cnt == BIT_LAST)
					begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= spart_pkg::TX_STOP;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				spart_pkg::TX_STOP:
				begin
					if (baud_cnt == BIT_LAST)
						state <= spart_pkg::TX_IDLE;
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				default:
					state <= spart_pkg::TX_IDLE;
			endcase
		end
	end

	// Latch on start, shift LSB out at each data bit end
	always_ff @(posedge clk)
	begin
		if (state == spart_pkg::TX_IDLE && tx_start)
			shreg <= tx_byte;
		else if (state == spart_pkg::TX_DATA && baud_cnt == BIT_LAST)
			shreg <= shreg >> 1;
	end

	// Line level decoded from state
	always_comb
	begin
		case (state)
			spart_pkg::TX_START: txd = 1'b0;
			spart_pkg::TX_DATA:  txd = shreg[0];
			default:             txd = 1'b1;
		endcase
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_spart_mem \
	-f spart_mem.f \
	-o sim_spart_mem

sim_out=$(./obj_dir/sim_spart_mem 2>&1) || true
printf '%s\n' "$sim_out"

if grep -qx "Simulation PASSED" <<< "$sim_out"; then
	exit 0
fi
exit 1

/* spart_mem.f */
+incdir+rtl
rtl/spart_pkg.sv
rtl/mem_pkg.sv
rtl/spart_rx.sv
rtl/spart_tx.sv
rtl/cmd_engine.sv
rtl/spart_mem_top.sv
dv/spart_mem_properties.sv
dv/spart_mem_checker.sv
dv/tb_spart_mem.sv
